// ==== fpu_params.svh ====
`ifndef FPU_PARAMS_SVH
`define FPU_PARAMS_SVH

// ---------------------------------------------------------------------------
// number format
// ---------------------------------------------------------------------------

// two's-complement fraction, value is frac / 2^15
`define FPU_FRAC_W 16

// two's-complement exponent
`define FPU_EXP_W 8

// exponent with two guard bits, as held by the exponent adder
`define FPU_EXP_GW 10

// FIC shift counter, wide enough for any shift count up to the fraction width
`define FPU_FIC_W 5

// largest shift that still leaves a useful bit in the fraction
`define FPU_NORM_LIMIT 15

`endif

// ==== fpu_pkg.sv ====
package fpu_pkg;

	`include "fpu_params.svh"

	// -----------------------------------------------------------------------
	// opcodes and sequencer states
	// -----------------------------------------------------------------------

	typedef enum logic [1:0] {
		OP_AF  = 2'd0,
		OP_SF  = 2'd1,
		OP_NRF = 2'd2
	} fp_op_t;

	typedef enum logic [2:0] {
		S_IDLE  = 3'd0,
		S_LOAD  = 3'd1,
		S_CMP   = 3'd2,
		S_ALIGN = 3'd3,
		S_ADD   = 3'd4,
		S_NORM  = 3'd5,
		S_DONE  = 3'd6
	} seq_state_t;

	// -----------------------------------------------------------------------
	// data and control bundles
	// -----------------------------------------------------------------------

	typedef struct packed {
		logic [`FPU_EXP_W-1:0]  exp;
		logic [`FPU_FRAC_W-1:0] frac;
	} fp_num_t;

	// zero, minus, exponent overflow
	typedef struct packed {
		logic z;
		logic m;
		logic v;
	} fp_flags_t;

	// one-cycle strobes from the sequencer to both units
	typedef struct packed {
		logic ld;
		logic cmp;
		logic shift;
		logic add;
		logic norm;
		logic fin;
	} phase_t;

endpackage

// ==== fpu_seq.sv ====
module fpu_seq
	import fpu_pkg::*;
(
	input  logic   __clk,
	input  logic   _0_f,
	input  logic   start,
	input  fp_op_t op,
	input  logic   g,
	input  logic   fic_zero,
	input  logic   frac_norm,
	output phase_t phase,
	output logic   busy,
	output logic   done
);

	seq_state_t state;
	seq_state_t state_nx;

	// -----------------------------------------------------------------------
	// state register
	// -----------------------------------------------------------------------

	always_ff @(posedge __clk or posedge _0_f) begin
		if (_0_f) begin
			state <= S_IDLE;
		end else begin
			state <= state_nx;
		end
	end

	always_comb begin
		state_nx = state;
		case (state)
			S_IDLE: begin
				if (start) begin
					state_nx = S_LOAD;
				end
			end
			// normalize-only skips compare, align and add
			S_LOAD: begin
				state_nx = (op == OP_NRF) ? S_NORM : S_CMP;
			end
			S_CMP: begin
				state_nx = S_ALIGN;
			end
			// difference too large, keep the larger operand as it is
			S_ALIGN: begin
				if (g || fic_zero) begin
					state_nx = S_ADD;
				end
			end
			S_ADD: begin
				state_nx = S_NORM;
			end
			S_NORM: begin
				if (frac_norm) begin
					state_nx = S_DONE;
				end
			end
			// busy is already low here, so a new start is taken at once
			S_DONE: begin
				state_nx = start ? S_LOAD : S_IDLE;
			end
			default: begin
				state_nx = S_IDLE;
			end
		endcase
	end

	// -----------------------------------------------------------------------
	// phase strobes
	// -----------------------------------------------------------------------

	assign phase.ld    = (state == S_LOAD);
	assign phase.cmp   = (state == S_CMP);
	assign phase.shift = (state == S_ALIGN) && !g && !fic_zero;
	assign phase.add   = (state == S_ADD);
	assign phase.norm  = (state == S_NORM) && !frac_norm;
	// last normalize cycle, results settle before done
	assign phase.fin   = (state == S_NORM) && frac_norm;

	assign busy = (state != S_IDLE) && (state != S_DONE);
	assign done = (state == S_DONE);

	// done closes a busy period and never overlaps it
	a_done_ends_busy: assert property (
		@(posedge __clk) disable iff (_0_f)
		done |-> $fell(busy)
	);

	a_load_after_start: assert property (
		@(posedge __clk) disable iff (_0_f)
		phase.ld |-> $past(start)
	);

endmodule

// ==== fpm_exp.sv ====
`include "fpu_params.svh"

module fpm_exp
	import fpu_pkg::*;
(
	input  logic                  __clk,
	input  logic                  _0_f,
	input  phase_t                phase,
	input  logic [`FPU_EXP_W-1:0] ea,
	input  logic [`FPU_EXP_W-1:0] eb,
	input  logic                  carry_fix,
	input  logic                  norm_step,
	input  logic                  frac_zero,
	output logic                  g,
	output logic                  wdt,
	output logic                  fic_zero,
	output logic                  exp_ovf,
	output logic [`FPU_EXP_W-1:0] res_exp
);

	localparam int EW = `FPU_EXP_W;
	localparam int GW = `FPU_EXP_GW;
	localparam int CW = `FPU_FIC_W;

	logic [EW-1:0] d_reg;
	logic [EW-1:0] b_reg;
	logic [GW-1:0] diff;
	logic [GW-1:0] diff_mag;
	logic          diff_big;
	logic [CW-1:0] fic;
	logic [CW-1:0] fic_ld;
	logic [GW-1:0] e_acc;

	// -----------------------------------------------------------------------
	// D and B exponent registers
	// -----------------------------------------------------------------------

	always_ff @(posedge __clk) begin
		if (phase.ld) begin
			d_reg <= ea;
			b_reg <= eb;
		end
	end

	// -----------------------------------------------------------------------
	// exponent adder with two guard bits
	// -----------------------------------------------------------------------

	// B - D, negative when b has the smaller exponent
	assign diff = {{(GW-EW){b_reg[EW-1]}}, b_reg} - {{(GW-EW){d_reg[EW-1]}}, d_reg};
	assign diff_mag = diff[GW-1] ? (~diff + 1'b1) : diff;
	assign diff_big = (diff_mag > `FPU_NORM_LIMIT);

	// nothing to shift when the smaller operand is lost entirely
	assign fic_ld = diff_big ? '0 : diff_mag[CW-1:0];

	always_ff @(posedge __clk or posedge _0_f) begin
		if (_0_f) begin
			g   <= 1'b0;
			wdt <= 1'b0;
		end else if (phase.cmp) begin
			g   <= diff_big;
			wdt <= diff[GW-1];
		end
	end

	// -----------------------------------------------------------------------
	// FIC shift counter
	// -----------------------------------------------------------------------

	always_ff @(posedge __clk or posedge _0_f) begin
		if (_0_f) begin
			fic <= '0;
		end else if (phase.cmp) begin
			fic <= fic_ld;
		end else if (phase.shift) begin
			fic <= fic - 1'b1;
		end
	end

	assign fic_zero = (fic == '0);

	// -----------------------------------------------------------------------
	// result exponent
	// -----------------------------------------------------------------------

	always_ff @(posedge __clk or posedge _0_f) begin
		if (_0_f) begin
			e_acc <= '0;
		end else if (phase.ld) begin
			// normalize-only works on a's exponent directly
			e_acc <= {{(GW-EW){ea[EW-1]}}, ea};
		end else if (phase.cmp) begin
			// start from the larger exponent
			if (diff[GW-1]) begin
				e_acc <= {{(GW-EW){d_reg[EW-1]}}, d_reg};
			end else begin
				e_acc <= {{(GW-EW){b_reg[EW-1]}}, b_reg};
			end
		end else if (carry_fix) begin
			e_acc <= e_acc + 1'b1;
		end else if (norm_step) begin
			e_acc <= e_acc - 1'b1;
		end else if (phase.fin && frac_zero) begin
			e_acc <= '0;
		end
	end

	// guard bits disagree with the sign once outside -128..127
	assign exp_ovf = !((&e_acc[GW-1:EW-1]) || !(|e_acc[GW-1:EW-1]));
	assign res_exp = e_acc[EW-1:0];

	a_fic_no_underflow: assert property (
		@(posedge __clk) disable iff (_0_f)
		phase.shift |-> !fic_zero
	);

endmodule

// ==== fpm_mant.sv ====
`include "fpu_params.svh"

module fpm_mant
	import fpu_pkg::*;
(
	input  logic                   __clk,
	input  logic                   _0_f,
	input  phase_t                 phase,
	input  fp_op_t                 op,
	input  logic [`FPU_FRAC_W-1:0] fa,
	input  logic [`FPU_FRAC_W-1:0] fb,
	input  logic                   wdt,
	input  logic                   g,
	input  logic                   exp_ovf,
	output logic                   frac_norm,
	output logic                   frac_zero,
	output logic                   carry_fix,
	output logic                   norm_step,
	output logic [`FPU_FRAC_W-1:0] res_frac,
	output fp_flags_t              flags
);

	localparam int FW = `FPU_FRAC_W;

	logic [FW-1:0] t_reg;
	logic [FW-1:0] m_reg;
	logic [FW-1:0] fb_neg;
	logic [FW:0]   sum;
	logic          sum_ovf;

	// -----------------------------------------------------------------------
	// operand preparation
	// -----------------------------------------------------------------------

	// -1.0 has no positive twin, clamp to the largest positive fraction
	assign fb_neg = (fb == {1'b1, {(FW-1){1'b0}}}) ? {1'b0, {(FW-1){1'b1}}}
		: (~fb + 1'b1);

	// -----------------------------------------------------------------------
	// adder with one guard bit
	// -----------------------------------------------------------------------

	assign sum     = {t_reg[FW-1], t_reg} + {m_reg[FW-1], m_reg};
	assign sum_ovf = sum[FW] ^ sum[FW-1];

	// -----------------------------------------------------------------------
	// M register, holds b until the add
	// -----------------------------------------------------------------------

	always_ff @(posedge __clk) begin
		if (phase.ld) begin
			m_reg <= (op == OP_SF) ? fb_neg : fb;
		end else if (phase.shift && wdt) begin
			m_reg <= {m_reg[FW-1], m_reg[FW-1:1]};
		end
	end

	// -----------------------------------------------------------------------
	// T register, accumulator and result
	// -----------------------------------------------------------------------

	always_ff @(posedge __clk or posedge _0_f) begin
		if (_0_f) begin
			t_reg <= '0;
		end else if (phase.ld) begin
			t_reg <= fa;
		end else if (phase.shift && !wdt) begin
			// arithmetic shift, low bit dropped
			t_reg <= {t_reg[FW-1], t_reg[FW-1:1]};
		end else if (phase.add) begin
			if (g) begin
				// larger operand only, like wt/wc in the old unit
				t_reg <= wdt ? t_reg : m_reg;
			end else if (sum_ovf) begin
				t_reg <= sum[FW:1];
			end else begin
				t_reg <= sum[FW-1:0];
			end
		end else if (phase.norm) begin
			t_reg <= {t_reg[FW-2:0], 1'b0};
		end
	end

	assign carry_fix = phase.add && !g && sum_ovf;

	// normalized when the two top bits differ
	assign frac_zero = (t_reg == '0);
	assign frac_norm = frac_zero || (t_reg[FW-1] ^ t_reg[FW-2]);
	assign norm_step = phase.norm && !frac_norm;

	assign res_frac = t_reg;

	// -----------------------------------------------------------------------
	// result flags
	// -----------------------------------------------------------------------

	always_ff @(posedge __clk or posedge _0_f) begin
		if (_0_f) begin
			flags <= '0;
		end else if (phase.fin) begin
			flags.z <= frac_zero;
			flags.m <= t_reg[FW-1];
			// a zero result clears the exponent, so no overflow
			flags.v <= exp_ovf && !frac_zero;
		end
	end

	a_shift_norm_excl: assert property (
		@(posedge __clk) disable iff (_0_f)
		!(phase.shift && phase.norm)
	);

endmodule

// ==== fpu_top.sv ====
`include "fpu_params.svh"

module fpu_top
	import fpu_pkg::*;
(
	input  logic      __clk,
	input  logic      _0_f,
	input  logic      start,
	input  fp_op_t    op,
	input  fp_num_t   a,
	input  fp_num_t   b,
	output logic      busy,
	output logic      done,
	output fp_num_t   res,
	output fp_flags_t flags
);

	phase_t                 phase;
	logic                   g;
	logic                   wdt;
	logic                   fic_zero;
	logic                   exp_ovf;
	logic                   frac_norm;
	logic                   frac_zero;
	logic                   carry_fix;
	logic                   norm_step;
	logic [`FPU_EXP_W-1:0]  res_exp;
	logic [`FPU_FRAC_W-1:0] res_frac;

	fpu_seq u_seq (
		.__clk     (__clk),
		._0_f      (_0_f),
		.start     (start),
		.op        (op),
		.g         (g),
		.fic_zero  (fic_zero),
		.frac_norm (frac_norm),
		.phase     (phase),
		.busy      (busy),
		.done      (done)
	);

	fpm_exp u_exp (
		.__clk     (__clk),
		._0_f      (_0_f),
		.phase     (phase),
		.ea        (a.exp),
		.eb        (b.exp),
		.carry_fix (carry_fix),
		.norm_step (norm_step),
		.frac_zero (frac_zero),
		.g         (g),
		.wdt       (wdt),
		.fic_zero  (fic_zero),
		.exp_ovf   (exp_ovf),
		.res_exp   (res_exp)
	);

	fpm_mant u_mant (
		.__clk     (__clk),
		._0_f      (_0_f),
		.phase     (phase),
		.op        (op),
		.fa        (a.frac),
		.fb        (b.frac),
		.wdt       (wdt),
		.g         (g),
		.exp_ovf   (exp_ovf),
		.frac_norm (frac_norm),
		.frac_zero (frac_zero),
		.carry_fix (carry_fix),
		.norm_step (norm_step),
		.res_frac  (res_frac),
		.flags     (flags)
	);

	assign res.exp  = res_exp;
	assign res.frac = res_frac;

endmodule

// ==== tb_fpu.sv ====
`include "fpu_params.svh"

module tb_fpu
	import fpu_pkg::*;
;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 10;
	localparam int OP_CYCLES    = 40;
	localparam int N_AF         = 200;
	localparam int N_SF         = 200;
	localparam int N_BIG        = 100;
	localparam int N_NRF        = 150;
	localparam int N_OVF        = 20;
	localparam int N_PROT       = 5;
	localparam int NUM_OPS      = N_AF + N_SF + N_BIG + N_NRF + N_OVF + N_PROT;

	typedef struct packed {
		fp_num_t   num;
		fp_flags_t flg;
	} result_t;

	logic      __clk;
	logic      _0_f;
	logic      start;
	fp_op_t    op;
	fp_num_t   a;
	fp_num_t   b;
	logic      busy;
	logic      done;
	fp_num_t   res;
	fp_flags_t flags;

	int errors;
	int checks;

	fpu_top UUT (
		.__clk (__clk),
		._0_f  (_0_f),
		.start (start),
		.op    (op),
		.a     (a),
		.b     (b),
		.busy  (busy),
		.done  (done),
		.res   (res),
		.flags (flags)
	);

	initial begin
		__clk = 1'b0;
		forever #4 __clk = ~__clk;
	end

	initial begin
		repeat (RESET_CYCLES + NUM_OPS * OP_CYCLES) @(posedge __clk);
		$display("watchdog expired after %0d cycles, simulation stopped",
			RESET_CYCLES + NUM_OPS * OP_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

	// ------------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------------

	function automatic logic [`FPU_FRAC_W-1:0] negate_sat(input logic [`FPU_FRAC_W-1:0] f);
		if (f == 16'h8000) begin
			return 16'h7fff;
		end
		return ~f + 16'd1;
	endfunction

	function automatic result_t expected_result(input fp_op_t o, input fp_num_t x,
		input fp_num_t y);
		result_t                r;
		int                     ex;
		int                     ey;
		int                     e;
		int                     fx;
		int                     fy;
		int                     s;
		int                     k;
		logic [`FPU_FRAC_W-1:0] yb;
		logic [`FPU_FRAC_W-1:0] t;
		ex = $signed(x.exp);
		ey = $signed(y.exp);
		yb = (o == OP_SF) ? negate_sat(y.frac) : y.frac;
		if (o == OP_NRF) begin
			t = x.frac;
			e = ex;
		end else begin
			fx = $signed(x.frac);
			fy = $signed(yb);
			e = (ex > ey) ? ex : ey;
			if (ex - ey > 15) begin
				t = x.frac;
			end else if (ey - ex > 15) begin
				t = yb;
			end else begin
				// smaller exponent operand is aligned, truncating
				if (ex > ey) begin
					fy = fy >>> (ex - ey);
				end else begin
					fx = fx >>> (ey - ex);
				end
				s = fx + fy;
				if (s > 32767 || s < -32768) begin
					s = s >>> 1;
					e = e + 1;
				end
				t = s[`FPU_FRAC_W-1:0];
			end
		end
		for (k = 0; k < `FPU_FRAC_W; k++) begin
			if (t != '0 && t[15] == t[14]) begin
				t = t << 1;
				e = e - 1;
			end
		end
		r.flg.z = (t == '0);
		r.flg.m = t[15];
		if (t == '0) begin
			e = 0;
		end
		r.flg.v = (e > 127) || (e < -128);
		r.num.exp = e[`FPU_EXP_W-1:0];
		r.num.frac = t;
		return r;
	endfunction

	// ------------------------------------------------------------------------
	// stimulus helpers
	// ------------------------------------------------------------------------

	function automatic int rand_int(input int lo, input int hi);
		return lo + int'($urandom_range(0, hi - lo));
	endfunction

	function automatic logic [`FPU_FRAC_W-1:0] rand_frac();
		logic [31:0] r;
		r = $urandom;
		return r[`FPU_FRAC_W-1:0];
	endfunction

	function automatic logic [`FPU_FRAC_W-1:0] rand_norm_frac();
		logic [`FPU_FRAC_W-1:0] f;
		f = rand_frac();
		f[14] = ~f[15];
		return f;
	endfunction

	function automatic fp_num_t make_num(input int e, input logic [`FPU_FRAC_W-1:0] f);
		fp_num_t n;
		n.exp = e[`FPU_EXP_W-1:0];
		n.frac = f;
		return n;
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("error %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	// one operation, poke issues a second start while busy
	task automatic run_op(input string name, input fp_op_t o, input fp_num_t x,
		input fp_num_t y, input bit poke, output fp_num_t got_res,
		output fp_flags_t got_flags);
		result_t want;
		int      cyc;
		want = expected_result(o, x, y);
		@(posedge __clk);
		start <= 1'b1;
		op <= o;
		a <= x;
		b <= y;
		@(posedge __clk);
		start <= 1'b0;
		if (poke) begin
			@(posedge __clk);
			start <= 1'b1;
			op <= OP_NRF;
			a <= ~x;
			b <= ~y;
			@(negedge __clk);
			check({name, " busy"}, 32'd1, 32'(busy));
			@(posedge __clk);
			start <= 1'b0;
		end
		cyc = 0;
		@(negedge __clk);
		while (!done && cyc < OP_CYCLES) begin
			@(negedge __clk);
			cyc++;
		end
		if (!done) begin
			errors++;
			$display("%s did not signal done within %0d cycles", name, OP_CYCLES);
		end
		got_res = res;
		got_flags = flags;
		check({name, " exp"}, 32'(want.num.exp), 32'(res.exp));
		check({name, " frac"}, 32'(want.num.frac), 32'(res.frac));
		check({name, " flags"}, 32'(want.flg), 32'(flags));
	endtask

	// ------------------------------------------------------------------------
	// tests
	// ------------------------------------------------------------------------

	task automatic random_arith(input fp_op_t o, input int n, input string tag);
		fp_num_t   x;
		fp_num_t   y;
		fp_num_t   r;
		fp_flags_t f;
		int        i;
		int        ea;
		for (i = 0; i < n; i++) begin
			ea = rand_int(-100, 100);
			x = make_num(ea, rand_norm_frac());
			y = make_num(ea + rand_int(-15, 15), rand_norm_frac());
			if (o == OP_SF && i % 10 == 0) begin
				y = x;
			end
			run_op($sformatf("%s_%0d", tag, i), o, x, y, 1'b0, r, f);
			// x - x is zero unless the negation saturated
			if (o == OP_SF && i % 10 == 0 && x.frac != 16'h8000) begin
				check($sformatf("%s_%0d zero exp", tag, i), 32'd0, 32'(r.exp));
				check($sformatf("%s_%0d zero z", tag, i), 32'd1, 32'(f.z));
			end
		end
	endtask

	task automatic big_diff();
		fp_num_t   x;
		fp_num_t   y;
		fp_num_t   r;
		fp_flags_t f;
		int        i;
		int        ea;
		int        d;
		for (i = 0; i < N_BIG; i++) begin
			ea = rand_int(-60, 60);
			d = rand_int(16, 60);
			x = make_num(ea, rand_frac());
			y = make_num((i % 2 == 0) ? ea + d : ea - d, rand_frac());
			run_op($sformatf("big_%0d", i), (i % 4 < 2) ? OP_AF : OP_SF, x, y, 1'b0, r, f);
		end
	endtask

	task automatic normalize_only();
		fp_num_t                x;
		fp_num_t                r;
		fp_flags_t              f;
		logic [`FPU_FRAC_W-1:0] fr;
		int                     i;
		for (i = 0; i < N_NRF; i++) begin
			fr = rand_frac();
			fr = $signed(fr) >>> rand_int(1, 15);
			if (i % 15 == 0) begin
				fr = '0;
			end
			x = make_num(rand_int(-128, 127), fr);
			run_op($sformatf("nrf_%0d", i), OP_NRF, x, make_num(0, '0), 1'b0, r, f);
			if (fr == '0) begin
				check($sformatf("nrf_%0d zero exp", i), 32'd0, 32'(r.exp));
				check($sformatf("nrf_%0d zero z", i), 32'd1, 32'(f.z));
			end
		end
	endtask

	// same sign, large fractions at +127 always carry
	task automatic exp_overflow();
		fp_num_t   x;
		fp_num_t   y;
		fp_num_t   r;
		fp_flags_t f;
		logic      neg;
		int        i;
		for (i = 0; i < N_OVF; i++) begin
			neg = i[0];
			x = make_num(127, {neg, ~neg, ~neg, 13'(rand_frac())});
			y = make_num(127, {neg, ~neg, ~neg, 13'(rand_frac())});
			run_op($sformatf("ovf_%0d", i), OP_AF, x, y, 1'b0, r, f);
			check($sformatf("ovf_%0d v", i), 32'd1, 32'(f.v));
			check($sformatf("ovf_%0d exp", i), 32'h80, 32'(r.exp));
		end
	endtask

	task automatic start_while_busy();
		fp_num_t   x;
		fp_num_t   y;
		fp_num_t   r;
		fp_flags_t f;
		int        i;
		int        ea;
		for (i = 0; i < N_PROT; i++) begin
			ea = rand_int(-100, 100);
			x = make_num(ea, rand_norm_frac());
			y = make_num(ea + rand_int(-15, 15), rand_norm_frac());
			run_op($sformatf("busy_start_%0d", i), OP_AF, x, y, 1'b1, r, f);
		end
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------

	initial begin
		errors = 0;
		checks = 0;
		void'($urandom(69601));
		_0_f = 1'b1;
		start = 1'b0;
		op = OP_AF;
		a = '0;
		b = '0;
		repeat (RESET_CYCLES) @(posedge __clk);
		_0_f <= 1'b0;
		@(negedge __clk);
		check("reset busy", 32'd0, 32'(busy));
		check("reset done", 32'd0, 32'(done));
		check("reset res", 32'd0, 32'(res));
		check("reset flags", 32'd0, 32'(flags));

		random_arith(OP_AF, N_AF, "af");
		random_arith(OP_SF, N_SF, "sf");
		big_diff();
		normalize_only();
		exp_overflow();
		start_while_busy();

		repeat (2) @(posedge __clk);
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+.
fpu_pkg.sv
fpu_seq.sv
fpm_exp.sv
fpm_mant.sv
fpu_top.sv
tb_fpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fpu
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= ALL CHECKS PASSED

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard *.sv *.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass message stands on a line of its own
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
